// ==== hw/fm_config.svh ====
// build-time sizes for the frequency and duty meter
// include wherever counter widths or the edge timeout are needed

`ifndef FM_CONFIG_SVH
`define FM_CONFIG_SVH

// span counter, high-time accumulator and both results
`define FM_CNT_W 32

// n_cycles input width
`define FM_N_W 16

// max pll_clk ticks from start or a rising edge to the next rising edge
`define FM_EDGE_TIMEOUT 1024

`endif

// ==== hw/fm_pkg.sv ====
// shared types for the frequency and duty meter
// import inside module bodies, or use scoped names in port lists

`include "fm_config.svh"

package fm_pkg;

    // pll_clk tick count, used for both results
    typedef logic [`FM_CNT_W-1:0] tick_t;

    // measurement gate states
    typedef enum logic [1:0] {
        GATE_IDLE,    // waiting for start
        GATE_ARMED,   // waiting for opening edge
        GATE_MEASURE  // window open, counting edges
    } gate_state_e;

endpackage

// ==== hw/gate_if.sv ====
// measurement window between the cycle gate and the high-time accumulator
// gate side drives the window controls, acc side returns the high count

`timescale 1ns/1ps

interface gate_if;
    import fm_pkg::*;

    logic  clear;       // opening edge, zero the accumulator
    logic  window;      // high while the period span is counted
    logic  close;       // closing edge
    logic  abort;       // edge timeout, measurement dropped
    tick_t high_ticks;  // high count including the current cycle

    modport gate (
        output clear, window, close, abort,
        input  high_ticks
    );

    modport acc (
        input  clear, window, close, abort,
        output high_ticks
    );

endinterface

// ==== hw/wave_edge_detect.sv ====
// brings the async wave_in into the pll_clk domain
// gives the synced level and a one-cycle pulse per rising edge, both 2 cycles late

`timescale 1ns/1ps

module wave_edge_detect (
    input  logic pll_clk,
    input  logic sys_rst_n,
    input  logic wave_in,    // async square wave
    output logic rise,       // one pulse per rising edge
    output logic level       // synced wave
);

    logic sync_meta;   // first flop, may go metastable
    logic sync_q;      // second flop, safe to use
    logic sync_dly;    // previous synced value

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sync_meta <= 1'b0;
            sync_q    <= 1'b0;
            sync_dly  <= 1'b0;
        end else begin
            sync_meta <= wave_in;
            sync_q    <= sync_meta;
            sync_dly  <= sync_q;
        end
    end

    assign level = sync_q;
    assign rise  = sync_q & ~sync_dly;   // low to high on the synced copy

    // an edge pulse needs a low sample before it can repeat
    a_rise_single : assert property (
        @(posedge pll_clk) disable iff (!sys_rst_n)
        rise |=> !rise
    );

endmodule

// ==== hw/cycle_gate.sv ====
// measurement control for the meter
// start arms, first rise opens the window, n-th later rise closes it
// also watches for a stalled input and drops the measurement on timeout

`timescale 1ns/1ps
`include "fm_config.svh"

module cycle_gate (
    input  logic                pll_clk,
    input  logic                sys_rst_n,
    input  logic                start,          // one-cycle strobe
    input  logic [`FM_N_W-1:0]  n_cycles,       // periods to span, 0 means 1
    input  logic                rise,           // synced rising edge pulse
    gate_if.gate                win,
    output fm_pkg::tick_t       period_ticks,
    output fm_pkg::tick_t       high_ticks,
    output logic                result_valid,
    output logic                timeout,
    output logic                busy
);
    import fm_pkg::*;

    localparam int GAP_W = $clog2(`FM_EDGE_TIMEOUT) + 1;

    gate_state_e        state;
    logic [`FM_N_W-1:0] n_tgt;      // cycle target latched at start
    logic [`FM_N_W-1:0] rise_cnt;   // rises seen since the opening one
    tick_t              span;       // window cycles before the current one
    logic [GAP_W-1:0]   gap;        // ticks since start or last rise

    logic take_start;
    logic open_hit;
    logic close_hit;
    logic gap_hit;
    logic abort_hit;

    assign take_start = (state == GATE_IDLE) && start;    // busy start is dropped
    assign open_hit   = (state == GATE_ARMED) && rise;
    assign close_hit  = (state == GATE_MEASURE) && rise && (rise_cnt == n_tgt - 1'b1);
    assign gap_hit    = (gap == GAP_W'(`FM_EDGE_TIMEOUT - 1));
    assign abort_hit  = (state != GATE_IDLE) && !rise && gap_hit;   // a rise rescues it

    assign win.clear = open_hit;
    assign win.close = close_hit;
    assign win.abort = abort_hit;
    assign busy      = (state != GATE_IDLE);

    // state machine and window level
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= GATE_IDLE;
            win.window <= 1'b0;
        end else begin
            case (state)
                GATE_IDLE: begin
                    if (start)
                        state <= GATE_ARMED;
                end
                GATE_ARMED: begin
                    if (abort_hit) begin
                        state <= GATE_IDLE;
                    end else if (rise) begin
                        state      <= GATE_MEASURE;
                        win.window <= 1'b1;   // opens next cycle
                    end
                end
                GATE_MEASURE: begin
                    if (abort_hit || close_hit) begin
                        state      <= GATE_IDLE;
                        win.window <= 1'b0;   // closing cycle still counts
                    end
                end
                default: begin
                    state      <= GATE_IDLE;
                    win.window <= 1'b0;
                end
            endcase
        end
    end

    // target, edge, span and gap counters
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            n_tgt    <= `FM_N_W'd1;
            rise_cnt <= '0;
            span     <= '0;
            gap      <= '0;
        end else begin
            if (take_start) begin
                n_tgt <= (n_cycles == '0) ? `FM_N_W'd1 : n_cycles;
                gap   <= '0;
            end else if (state != GATE_IDLE) begin
                gap <= rise ? '0 : gap + 1'b1;   // restart on every edge
            end

            if (open_hit) begin
                span     <= '0;
                rise_cnt <= '0;
            end else if (state == GATE_MEASURE) begin
                span <= span + 1'b1;
                if (rise)
                    rise_cnt <= rise_cnt + 1'b1;
            end
        end
    end

    // result register, held until the next good measurement
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            period_ticks <= '0;
            high_ticks   <= '0;
            result_valid <= 1'b0;
            timeout      <= 1'b0;
        end else begin
            result_valid <= close_hit;
            timeout      <= abort_hit;
            if (close_hit) begin
                period_ticks <= span + 1'b1;     // include the closing cycle
                high_ticks   <= win.high_ticks;  // acc output already counts it
            end
        end
    end

    // a measurement ends one way only
    a_end_excl : assert property (
        @(posedge pll_clk) disable iff (!sys_rst_n)
        !(result_valid && timeout)
    );

    // window register must track the measure state
    a_window_state : assert property (
        @(posedge pll_clk) disable iff (!sys_rst_n)
        win.window |-> (state == GATE_MEASURE)
    );

endmodule

// ==== hw/high_time_acc.sv ====
// counts pll_clk cycles with the synced wave high inside the window
// high_ticks includes the current cycle so the gate can latch it on close

`timescale 1ns/1ps

module high_time_acc (
    input  logic pll_clk,
    input  logic sys_rst_n,
    input  logic level,     // synced wave, same latency as rise
    gate_if.acc  win
);
    import fm_pkg::*;

    tick_t acc;       // registered count
    tick_t acc_nxt;
    logic  frozen;    // set on close until the next clear
    logic  count_en;

    assign count_en = win.window && level && !frozen && (acc != '1);   // saturate at max

    always_comb begin
        acc_nxt = acc;
        if (win.clear || win.abort)
            acc_nxt = '0;
        else if (count_en)
            acc_nxt = acc + 1'b1;
    end

    assign win.high_ticks = acc_nxt;

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            acc    <= '0;
            frozen <= 1'b0;
        end else begin
            acc <= acc_nxt;
            if (win.clear || win.abort)
                frozen <= 1'b0;
            else if (win.close)
                frozen <= 1'b1;   // hold the count after the last edge
        end
    end

    // outside the window the count only holds or clears
    a_no_count_idle : assert property (
        @(posedge pll_clk) disable iff (!sys_rst_n)
        !win.window |=> (acc == $past(acc)) || (acc == '0)
    );

endmodule

// ==== hw/freq_meter_top.sv ====
// frequency and duty meter top, all on pll_clk
// pulse start, wait for result_valid or timeout, then read both counts

`timescale 1ns/1ps
`include "fm_config.svh"

module freq_meter_top (
    input  logic                pll_clk,
    input  logic                sys_rst_n,
    input  logic                wave_in,        // async input wave
    input  logic                start,
    input  logic [`FM_N_W-1:0]  n_cycles,
    output fm_pkg::tick_t       period_ticks,   // ticks over n periods
    output fm_pkg::tick_t       high_ticks,     // high ticks over n periods
    output logic                result_valid,
    output logic                timeout,
    output logic                busy
);
    import fm_pkg::*;

    logic rise;
    logic level;

    gate_if win_if ();

    wave_edge_detect u_edge (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .wave_in   (wave_in),
        .rise      (rise),
        .level     (level)
    );

    cycle_gate u_gate (
        .pll_clk      (pll_clk),
        .sys_rst_n    (sys_rst_n),
        .start        (start),
        .n_cycles     (n_cycles),
        .rise         (rise),
        .win          (win_if.gate),
        .period_ticks (period_ticks),
        .high_ticks   (high_ticks),
        .result_valid (result_valid),
        .timeout      (timeout),
        .busy         (busy)
    );

    high_time_acc u_acc (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .level     (level),
        .win       (win_if.acc)
    );

endmodule

// ==== verification/freq_meter_checker.sv ====
// watches the meter outputs and compares them with values derived from each test line
// armed by test_go, prints one line per test, counts go back to the testbench

`timescale 1ns/1ps
`include "fm_config.svh"

module freq_meter_checker (
    input  logic          pll_clk,
    input  logic          sys_rst_n,
    input  fm_pkg::tick_t period_ticks,
    input  fm_pkg::tick_t high_ticks,
    input  logic          result_valid,
    input  logic          timeout,
    input  logic          busy,
    input  logic          test_go,
    input  int            test_num,
    input  int            high_len,
    input  int            low_len,
    input  int            n_cycles,
    input  int            expect_to,
    output int            done_cnt,
    output int            pass_cnt,
    output int            fail_cnt
);
    import fm_pkg::*;

    int    err_cnt;       // errors in the running test
    tick_t last_period;   // result the DUT should be holding
    tick_t last_high;

    initial begin
        done_cnt    = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        last_period = '0;
        last_high   = '0;
    end

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            err_cnt = err_cnt + 1;
        end
    endtask

    task automatic finish_test(int num, string kind);
        if (err_cnt == 0) begin
            pass_cnt = pass_cnt + 1;
            $display("test %0d (%s): ok", num, kind);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("test %0d (%s): FAILED, %0d errors", num, kind, err_cnt);
        end
        done_cnt = done_cnt + 1;
    endtask

    // outputs zero once reset lets go
    always @(posedge sys_rst_n) begin
        @(negedge pll_clk);
        err_cnt = 0;
        check_value("period_ticks", 0, period_ticks);
        check_value("high_ticks", 0, high_ticks);
        check_value("result_valid", 0, result_valid);
        check_value("timeout", 0, timeout);
        check_value("busy", 0, busy);
        finish_test(0, "reset");
    end

    task automatic run_test();
        tick_t exp_period;
        tick_t exp_high;
        int    n_eff;
        int    limit;
        int    cyc;
        bit    ended;
        bit    busy_bad;
        err_cnt    = 0;
        n_eff      = (n_cycles == 0) ? 1 : n_cycles;   // 0 acts as 1
        exp_period = tick_t'(n_eff) * tick_t'(high_len + low_len);
        exp_high   = tick_t'(n_eff) * tick_t'(high_len);
        limit      = (high_len + low_len) * (n_eff + 2) + 2 * `FM_EDGE_TIMEOUT + 50;
        check_value("busy", 0, busy);   // start not taken yet
        @(negedge pll_clk);
        cyc      = 0;
        ended    = 1'b0;
        busy_bad = 1'b0;
        while (!ended && cyc < limit) begin
            if (result_valid === 1'b1 || timeout === 1'b1) begin
                ended = 1'b1;
            end else begin
                if (busy !== 1'b1 && !busy_bad) begin
                    check_value("busy", 1, busy);   // report once per test
                    busy_bad = 1'b1;
                end
                @(negedge pll_clk);
                cyc = cyc + 1;
            end
        end
        if (!ended) begin
            $display("test %0d: neither result_valid nor timeout in %0d cycles", test_num, limit);
            err_cnt = err_cnt + 1;
        end else begin
            check_value("result_valid", expect_to ? 0 : 1, result_valid);
            check_value("timeout", expect_to ? 1 : 0, timeout);
            check_value("busy", 0, busy);   // falls with the end pulse
            if (expect_to == 0) begin
                last_period = exp_period;
                last_high   = exp_high;
            end
            check_value("period_ticks", last_period, period_ticks);
            check_value("high_ticks", last_high, high_ticks);
            @(negedge pll_clk);
            check_value("result_valid", 0, result_valid);   // single-cycle pulses
            check_value("timeout", 0, timeout);
            check_value("busy", 0, busy);
            check_value("period_ticks", last_period, period_ticks);   // held
            check_value("high_ticks", last_high, high_ticks);
        end
        finish_test(test_num, expect_to ? "timeout" : "measure");
    endtask

    always @(negedge pll_clk) begin
        if (test_go)
            run_test();
    end

endmodule

// ==== verification/freq_meter_tb.sv ====
// testbench for the frequency and duty meter
// reads one test per line and drives start and the square wave
// the checker module does the comparing

`timescale 1ns/1ps
`include "fm_config.svh"

module freq_meter_tb;
    import fm_pkg::*;

    logic               pll_clk;
    logic               sys_rst_n;
    logic               wave_in;
    logic               start;
    logic [`FM_N_W-1:0] n_cycles;
    tick_t              period_ticks;
    tick_t              high_ticks;
    logic               result_valid;
    logic               timeout;
    logic               busy;

    logic  test_go;      // arms the checker in the start cycle
    int    test_num;
    int    high_len;
    int    low_len;
    int    n_field;
    int    expect_to;
    int    done_cnt;     // reset check counts as the first
    int    pass_cnt;
    int    fail_cnt;
    int    fd;
    int    seed_ret;
    bit    aborted;      // a wait ran out
    string line;

    freq_meter_top dut_i (
        .pll_clk(pll_clk), .sys_rst_n(sys_rst_n), .wave_in(wave_in), .start(start),
        .n_cycles(n_cycles), .period_ticks(period_ticks), .high_ticks(high_ticks),
        .result_valid(result_valid), .timeout(timeout), .busy(busy)
    );

    freq_meter_checker chk_i (
        .pll_clk(pll_clk), .sys_rst_n(sys_rst_n), .period_ticks(period_ticks),
        .high_ticks(high_ticks), .result_valid(result_valid), .timeout(timeout),
        .busy(busy), .test_go(test_go), .test_num(test_num), .high_len(high_len),
        .low_len(low_len), .n_cycles(n_field), .expect_to(expect_to),
        .done_cnt(done_cnt), .pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
    );

    always #2 pll_clk = ~pll_clk;   // 4 ns period

    // wave level at tick ph where each period starts low
    function automatic logic wave_at(int ph);
        if (low_len == 0)
            return 1'b1;            // stuck high
        return (ph % (high_len + low_len)) >= low_len;
    endfunction

    // spin the clock until the checker has finished n tests
    task automatic wait_checker(int n, int limit);
        int cyc;
        cyc = 0;
        while (done_cnt < n && cyc < limit) begin
            @(posedge pll_clk);
            cyc = cyc + 1;
            start   <= (cyc == 3);  // lands while busy and must be ignored
            if (cyc == 3)
                n_cycles <= n_cycles + 2'd2;   // a taken start would latch this
            test_go <= 1'b0;
            wave_in <= wave_at(cyc);
        end
        if (done_cnt < n) begin
            $display("checker did not finish test %0d within %0d cycles", n - 1, limit);
            aborted = 1'b1;
        end
    endtask

    task automatic run_one_test();
        int gap;
        gap = $urandom_range(9, 2);  // random idle time with the wave low
        repeat (gap) begin
            @(posedge pll_clk);
            wave_in <= 1'b0;
        end
        test_num = test_num + 1;
        @(posedge pll_clk);
        start    <= 1'b1;
        test_go  <= 1'b1;
        n_cycles <= `FM_N_W'(n_field);
        wave_in  <= wave_at(0);
        wait_checker(test_num + 1, (high_len + low_len) * (n_field + 3)
                     + 2 * `FM_EDGE_TIMEOUT + 100);
    endtask

    initial begin
        pll_clk   = 1'b0;
        sys_rst_n = 1'b0;
        wave_in   = 1'b0;
        start     = 1'b0;
        n_cycles  = '0;
        test_go   = 1'b0;
        test_num  = 0;
        aborted   = 1'b0;
        seed_ret  = $urandom(32'h836dd052);
        repeat (10) @(posedge pll_clk);
        sys_rst_n <= 1'b1;
        wait_checker(1, 20);         // reset values
        fd = $fopen("verification/freq_meter_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/freq_meter_tests.txt");
            aborted = 1'b1;
        end
        while (!aborted && fd != 0 && !$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) begin
                if ($sscanf(line, "%d %d %d %d", high_len, low_len, n_field, expect_to) == 4)
                    run_one_test();   // comment and blank lines skipped
            end
        end
        if (fd != 0)
            $fclose(fd);
        repeat (4) @(posedge pll_clk);
        $display("tests: %0d, passed: %0d, failed: %0d", done_cnt, pass_cnt, fail_cnt);
        if (!aborted && fail_cnt == 0 && test_num > 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== verification/freq_meter_tests.txt ====
# columns: high_len low_len n_cycles expect_timeout, lengths in pll_clk ticks
# low_len 0 holds wave_in high for the whole test
5 5 4 0
3 7 10 0
1 9 8 0      # narrow high pulse
9 1 8 0      # narrow low pulse
1 1 16 0     # fastest wave
6 4 0 0      # n_cycles 0 counts one period
20 30 3 0
1 1200 2 1   # no edge before the gap limit
0 0 3 1      # stuck high, timeout after the opening edge
12 3 5 0

// ==== tb.f ====
+incdir+hw
hw/fm_pkg.sv
hw/gate_if.sv
hw/wave_edge_detect.sv
hw/cycle_gate.sv
hw/high_time_acc.sv
hw/freq_meter_top.sv
verification/freq_meter_checker.sv
verification/freq_meter_tb.sv

// ==== Bender.yml ====
package:
  name: freq_meter

sources:
  - include_dirs:
      - hw
    files:
      - hw/fm_pkg.sv
      - hw/gate_if.sv
      - hw/wave_edge_detect.sv
      - hw/cycle_gate.sv
      - hw/high_time_acc.sv
      - hw/freq_meter_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/freq_meter_checker.sv
      - verification/freq_meter_tb.sv
